// ==== trace_pkg.sv ====
// shared widths, packet formats and encodings for the trace encoder
// imported by every design unit and by the testbench
package trace_pkg;

    // core side widths
    localparam int unsigned XLEN      = 32;
    localparam int unsigned INST_LEN  = 32;
    localparam int unsigned CAUSE_LEN = 5;
    localparam int unsigned PRIV_LEN  = 2;

    // branch map capacity and counter width
    localparam int unsigned BRANCH_MAP_LEN   = 31;
    localparam int unsigned BRANCH_COUNT_LEN = 5;

    // packet output widths
    localparam int unsigned PAYLOAD_LEN = 72;
    localparam int unsigned PTYPE_LEN   = 4;
    localparam int unsigned P_LEN       = 4;

    // packet lengths in bytes
    localparam logic [P_LEN-1:0] LEN_F3_START = 4'd5;
    localparam logic [P_LEN-1:0] LEN_F3_TRAP  = 4'd6;
    localparam logic [P_LEN-1:0] LEN_F2       = 4'd4;
    localparam logic [P_LEN-1:0] LEN_F1       = 4'd9;

    // packet format, high half of the packet type
    typedef enum logic [1:0] {
        F1 = 2'd1,
        F2 = 2'd2,
        F3 = 2'd3
    } format_e;

    // format 3 subformat, low half of the packet type
    typedef enum logic [1:0] {
        SUB_START = 2'd0,
        SUB_TRAP  = 2'd1
    } f3_sub_e;

    // major opcodes that matter to the encoder
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [1:0] {
        ST_OFF,
        ST_START,
        ST_RUN
    } decider_state_e;

endpackage

// ==== trace_if.sv ====
// bundles between the encoder stages
// window -> decider, decider <-> branch map, decider -> emitter

// classified nc/tc/lc view of the retired instruction stream
interface retire_window_if import trace_pkg::*; #(
    parameter int unsigned XLEN      = trace_pkg::XLEN,
    parameter int unsigned CAUSE_LEN = trace_pkg::CAUSE_LEN
);
    logic                 advance;
    // this cycle
    logic                 tc_valid;
    logic [XLEN-1:0]      tc_pc;
    logic [PRIV_LEN-1:0]  tc_priv;
    logic                 tc_branch;
    logic                 tc_taken;
    // last cycle
    logic                 lc_valid;
    logic                 lc_exception;
    logic [CAUSE_LEN-1:0] lc_cause;
    logic                 lc_interrupt;
    logic                 lc_updiscon;

    modport source (
        output advance, tc_valid, tc_pc, tc_priv, tc_branch, tc_taken,
        output lc_valid, lc_exception, lc_cause, lc_interrupt, lc_updiscon
    );
    modport sink (
        input advance, tc_valid, tc_pc, tc_priv, tc_branch, tc_taken,
        input lc_valid, lc_exception, lc_cause, lc_interrupt, lc_updiscon
    );
endinterface

// branch map control and status
interface branch_map_if import trace_pkg::*; #(
    parameter int unsigned BRANCH_MAP_LEN = trace_pkg::BRANCH_MAP_LEN
);
    logic                        record;
    logic                        taken;
    logic                        flush;
    logic [BRANCH_COUNT_LEN-1:0] count;
    logic [BRANCH_MAP_LEN-1:0]   map;
    logic                        full;

    modport master (output record, taken, flush, input count, map, full);
    modport sink (input record, taken, flush, output count, map, full);
endinterface

// one packet request per fire strobe
interface packet_req_if import trace_pkg::*; #(
    parameter int unsigned XLEN           = trace_pkg::XLEN,
    parameter int unsigned CAUSE_LEN      = trace_pkg::CAUSE_LEN,
    parameter int unsigned BRANCH_MAP_LEN = trace_pkg::BRANCH_MAP_LEN
);
    logic                        fire;
    format_e                     format;
    f3_sub_e                     subformat;
    logic [XLEN-1:0]             address;
    logic [PRIV_LEN-1:0]         priv;
    logic [CAUSE_LEN-1:0]        cause;
    logic                        interrupt;
    logic [BRANCH_COUNT_LEN-1:0] count;
    logic [BRANCH_MAP_LEN-1:0]   map;

    modport source (output fire, format, subformat, address, priv, cause, interrupt, count, map);
    modport sink (input fire, format, subformat, address, priv, cause, interrupt, count, map);
endinterface

// ==== retire_window.sv ====
// three-deep window of retired instructions (nc, tc, lc)
// classifies branches, taken branches and uninferable jumps for the decider
module retire_window import trace_pkg::*; #(
    parameter int unsigned XLEN      = trace_pkg::XLEN,
    parameter int unsigned CAUSE_LEN = trace_pkg::CAUSE_LEN
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 trace_enable_i,
    input  logic                 inst_valid_i,
    input  logic [XLEN-1:0]      pc_i,
    input  logic [INST_LEN-1:0]  inst_data_i,
    input  logic                 exception_i,
    input  logic                 interrupt_i,
    input  logic [CAUSE_LEN-1:0] cause_i,
    input  logic [PRIV_LEN-1:0]  priv_lvl_i,
    retire_window_if.source      win
);

    logic                 advance;
    // next cycle, straight from the core
    logic                 nc_valid_q;
    logic [XLEN-1:0]      nc_pc_q;
    logic [6:0]           nc_opcode_q;
    logic                 nc_exc_q;
    logic                 nc_int_q;
    logic [CAUSE_LEN-1:0] nc_cause_q;
    logic [PRIV_LEN-1:0]  nc_priv_q;
    logic                 nc_branch;
    logic                 nc_updiscon;
    // this cycle
    logic                 tc_valid_q;
    logic [XLEN-1:0]      tc_pc_q;
    logic [PRIV_LEN-1:0]  tc_priv_q;
    logic                 tc_branch_q;
    logic                 tc_updiscon_q;
    logic                 tc_exc_q;
    logic                 tc_int_q;
    logic [CAUSE_LEN-1:0] tc_cause_q;
    // last cycle
    logic                 lc_valid_q;
    logic                 lc_exc_q;
    logic                 lc_int_q;
    logic [CAUSE_LEN-1:0] lc_cause_q;
    logic                 lc_updiscon_q;

    // a new instruction enters nc on this edge
    assign advance = inst_valid_i && trace_enable_i;

    // opcode decode on nc, carried along as flags
    assign nc_branch   = (nc_opcode_q == OP_BRANCH);
    assign nc_updiscon = (nc_opcode_q == OP_JALR);

    // valid bits follow the shift, cleared while tracing is off
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            nc_valid_q <= 1'b0;
            tc_valid_q <= 1'b0;
            lc_valid_q <= 1'b0;
        end else if (!trace_enable_i) begin
            nc_valid_q <= 1'b0;
            tc_valid_q <= 1'b0;
            lc_valid_q <= 1'b0;
        end else if (advance) begin
            nc_valid_q <= 1'b1;
            tc_valid_q <= nc_valid_q;
            lc_valid_q <= tc_valid_q;
        end
    end

    // instruction records, qualified by the valid bits above
    always_ff @(posedge clk_i) begin
        if (advance) begin
            nc_pc_q       <= pc_i;
            nc_opcode_q   <= inst_data_i[6:0];
            nc_exc_q      <= exception_i;
            nc_int_q      <= interrupt_i;
            nc_cause_q    <= cause_i;
            nc_priv_q     <= priv_lvl_i;
            tc_pc_q       <= nc_pc_q;
            tc_priv_q     <= nc_priv_q;
            tc_branch_q   <= nc_branch;
            tc_updiscon_q <= nc_updiscon;
            tc_exc_q      <= nc_exc_q;
            tc_int_q      <= nc_int_q;
            tc_cause_q    <= nc_cause_q;
            lc_exc_q      <= tc_exc_q;
            lc_int_q      <= tc_int_q;
            lc_cause_q    <= tc_cause_q;
            lc_updiscon_q <= tc_updiscon_q;
        end
    end

    assign win.advance   = advance;
    assign win.tc_valid  = tc_valid_q;
    assign win.tc_pc     = tc_pc_q;
    assign win.tc_priv   = tc_priv_q;
    assign win.tc_branch = tc_branch_q;
    // no compressed instructions, so the fall-through is always pc + 4
    assign win.tc_taken  = tc_branch_q && nc_valid_q && (nc_pc_q != tc_pc_q + XLEN'(4));

    assign win.lc_valid     = lc_valid_q;
    assign win.lc_exception = lc_exc_q;
    assign win.lc_cause     = lc_cause_q;
    assign win.lc_interrupt = lc_int_q;
    assign win.lc_updiscon  = lc_updiscon_q;

endmodule

// ==== branch_map.sv ====
// branch outcome map, bit 0 is the oldest entry and 1 means not taken
// written by the decider, read back for format 1 packets
module branch_map import trace_pkg::*; #(
    parameter int unsigned BRANCH_MAP_LEN = trace_pkg::BRANCH_MAP_LEN
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    branch_map_if.sink  bm
);

    localparam logic [BRANCH_COUNT_LEN-1:0] COUNT_MAX = BRANCH_COUNT_LEN'(BRANCH_MAP_LEN);

    logic [BRANCH_COUNT_LEN-1:0] count_q;
    logic [BRANCH_COUNT_LEN-1:0] count_d;
    logic [BRANCH_MAP_LEN-1:0]   map_q;
    logic [BRANCH_MAP_LEN-1:0]   map_d;

    always_comb begin
        count_d = count_q;
        map_d   = map_q;
        if (bm.flush) begin
            // flush wins, a recorded branch starts the new map
            count_d = bm.record ? BRANCH_COUNT_LEN'(1) : '0;
            map_d   = '0;
            map_d[0] = bm.record && !bm.taken;
        end else if (bm.record && (count_q < COUNT_MAX)) begin
            // append at the first free slot
            map_d[count_q] = !bm.taken;
            count_d        = count_q + BRANCH_COUNT_LEN'(1);
        end
    end

    // map bits above the count stay zero, so the map is reset too
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
            map_q   <= '0;
        end else begin
            count_q <= count_d;
            map_q   <= map_d;
        end
    end

    assign bm.count = count_q;
    assign bm.map   = map_q;
    assign bm.full  = (count_q == COUNT_MAX);

endmodule

// ==== packet_decider.sv ====
// decides which packet, if any, the tc instruction needs
// combinational request plus the start/run state, drives the branch map
module packet_decider import trace_pkg::*; #(
    parameter int unsigned BRANCH_MAP_LEN = trace_pkg::BRANCH_MAP_LEN
) (
    input  logic           clk_i,
    input  logic           rst_ni,
    retire_window_if.sink  win,
    branch_map_if.master   bm,
    packet_req_if.source   req
);

    localparam logic [BRANCH_COUNT_LEN-1:0] COUNT_MAX = BRANCH_COUNT_LEN'(BRANCH_MAP_LEN);

    decider_state_e              state_q;
    decider_state_e              state_d;
    logic                        decide;
    logic                        lc_trap;
    logic                        lc_discon;
    logic                        win_empty;
    logic [BRANCH_COUNT_LEN-1:0] count_with;
    logic [BRANCH_MAP_LEN-1:0]   map_with;

    // one decision per accepted instruction once tc holds something
    assign decide    = win.advance && win.tc_valid;
    assign lc_trap   = win.lc_valid && win.lc_exception;
    assign lc_discon = win.lc_valid && win.lc_updiscon;
    assign win_empty = !win.tc_valid && !win.lc_valid;

    // map and count as they would be with the tc branch included
    assign count_with = bm.count + BRANCH_COUNT_LEN'(win.tc_branch);
    always_comb begin
        map_with = bm.map;
        if (win.tc_branch && !bm.full) begin
            map_with[bm.count] = !win.tc_taken;
        end
    end

    always_comb begin
        req.fire      = 1'b0;
        req.format    = F2;
        req.subformat = SUB_START;
        bm.record     = 1'b0;
        bm.flush      = 1'b0;
        if (decide) begin
            if (lc_trap) begin
                // handler entry after an exception
                req.fire      = 1'b1;
                req.format    = F3;
                req.subformat = SUB_TRAP;
                bm.flush      = 1'b1;
                bm.record     = win.tc_branch;
            end else if (state_q == ST_START) begin
                req.fire   = 1'b1;
                req.format = F3;
                bm.flush   = 1'b1;
                bm.record  = win.tc_branch;
            end else if (lc_discon) begin
                // jalr target, with the map if there is one
                req.fire   = 1'b1;
                req.format = (count_with != '0) ? F1 : F2;
                bm.flush   = 1'b1;
            end else if (count_with == COUNT_MAX) begin
                req.fire   = 1'b1;
                req.format = F1;
                bm.flush   = 1'b1;
            end else begin
                bm.record = win.tc_branch;
            end
        end
    end

    assign bm.taken      = win.tc_taken;
    assign req.address   = win.tc_pc;
    assign req.priv      = win.tc_priv;
    assign req.cause     = win.lc_cause;
    assign req.interrupt = win.lc_interrupt;
    assign req.count     = count_with;
    assign req.map       = map_with;

    // off until the first accept, start until the first packet
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_OFF:   if (win.advance) state_d = ST_START;
            ST_START: if (req.fire) state_d = ST_RUN;
            // window only drains when trace gets disabled
            ST_RUN:   if (win_empty) state_d = win.advance ? ST_START : ST_OFF;
            default:  state_d = ST_OFF;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_OFF;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== packet_emitter.sv ====
// registers the packet request into type, length and payload
// packet_valid_o is a one-cycle strobe per request
module packet_emitter import trace_pkg::*; #(
    parameter int unsigned XLEN           = trace_pkg::XLEN,
    parameter int unsigned CAUSE_LEN      = trace_pkg::CAUSE_LEN,
    parameter int unsigned BRANCH_MAP_LEN = trace_pkg::BRANCH_MAP_LEN
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    packet_req_if.sink             req,
    output logic                   packet_valid_o,
    output logic [PTYPE_LEN-1:0]   packet_type_o,
    output logic [P_LEN-1:0]       packet_length_o,
    output logic [PAYLOAD_LEN-1:0] packet_payload_o
);

    logic [P_LEN-1:0]       length_d;
    logic [PAYLOAD_LEN-1:0] payload_d;

    // address always sits at the bottom, format fields just above it
    always_comb begin
        payload_d             = '0;
        payload_d[XLEN-1:0]   = req.address;
        length_d              = LEN_F2;
        case (req.format)
            F3: begin
                if (req.subformat == SUB_TRAP) begin
                    length_d                     = LEN_F3_TRAP;
                    payload_d[XLEN +: CAUSE_LEN] = req.cause;
                    payload_d[XLEN + CAUSE_LEN]  = req.interrupt;
                end else begin
                    length_d                    = LEN_F3_START;
                    payload_d[XLEN +: PRIV_LEN] = req.priv;
                end
            end
            F1: begin
                length_d                          = LEN_F1;
                payload_d[XLEN +: BRANCH_MAP_LEN] = req.map;
                payload_d[XLEN + BRANCH_MAP_LEN +: BRANCH_COUNT_LEN] = req.count;
            end
            default: length_d = LEN_F2;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o <= 1'b0;
        end else begin
            packet_valid_o <= req.fire;
        end
    end

    // held until the next packet
    always_ff @(posedge clk_i) begin
        if (req.fire) begin
            packet_type_o    <= {req.format, req.subformat};
            packet_length_o  <= length_d;
            packet_payload_o <= payload_d;
        end
    end

endmodule

// ==== trace_encoder.sv ====
// instruction trace encoder top level
// retired instructions in, compressed trace packets out, plain ports only
module trace_encoder import trace_pkg::*; #(
    parameter int unsigned XLEN           = trace_pkg::XLEN,
    parameter int unsigned CAUSE_LEN      = trace_pkg::CAUSE_LEN,
    parameter int unsigned BRANCH_MAP_LEN = trace_pkg::BRANCH_MAP_LEN
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   trace_enable_i,
    input  logic                   inst_valid_i,
    input  logic [XLEN-1:0]        pc_i,
    input  logic [INST_LEN-1:0]    inst_data_i,
    input  logic                   exception_i,
    input  logic                   interrupt_i,
    input  logic [CAUSE_LEN-1:0]   cause_i,
    input  logic [PRIV_LEN-1:0]    priv_lvl_i,
    output logic                   packet_valid_o,
    output logic [PTYPE_LEN-1:0]   packet_type_o,
    output logic [P_LEN-1:0]       packet_length_o,
    output logic [PAYLOAD_LEN-1:0] packet_payload_o
);

    retire_window_if #(.XLEN(XLEN), .CAUSE_LEN(CAUSE_LEN)) win ();
    branch_map_if #(.BRANCH_MAP_LEN(BRANCH_MAP_LEN)) bm ();
    packet_req_if #(
        .XLEN(XLEN), .CAUSE_LEN(CAUSE_LEN), .BRANCH_MAP_LEN(BRANCH_MAP_LEN)
    ) req ();

    // sample and classify
    retire_window #(.XLEN(XLEN), .CAUSE_LEN(CAUSE_LEN)) i_retire_window (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .trace_enable_i (trace_enable_i),
        .inst_valid_i   (inst_valid_i),
        .pc_i           (pc_i),
        .inst_data_i    (inst_data_i),
        .exception_i    (exception_i),
        .interrupt_i    (interrupt_i),
        .cause_i        (cause_i),
        .priv_lvl_i     (priv_lvl_i),
        .win            (win)
    );

    branch_map #(.BRANCH_MAP_LEN(BRANCH_MAP_LEN)) i_branch_map (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .bm     (bm)
    );

    // priority decision on the tc instruction
    packet_decider #(.BRANCH_MAP_LEN(BRANCH_MAP_LEN)) i_packet_decider (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .win    (win),
        .bm     (bm),
        .req    (req)
    );

    packet_emitter #(
        .XLEN(XLEN), .CAUSE_LEN(CAUSE_LEN), .BRANCH_MAP_LEN(BRANCH_MAP_LEN)
    ) i_packet_emitter (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .req              (req),
        .packet_valid_o   (packet_valid_o),
        .packet_type_o    (packet_type_o),
        .packet_length_o  (packet_length_o),
        .packet_payload_o (packet_payload_o)
    );

endmodule

// ==== trace_encoder_checker.sv ====
// concurrent assertions on the trace encoder packet outputs
// bound into trace_encoder, failures counted for the testbench report
module trace_encoder_checker import trace_pkg::*; (
    input logic                   clk_i,
    input logic                   rst_ni,
    input logic                   inst_valid_i,
    input logic                   packet_valid_i,
    input logic [PTYPE_LEN-1:0]   packet_type_i,
    input logic [P_LEN-1:0]       packet_length_i,
    input logic [PAYLOAD_LEN-1:0] packet_payload_i
);

    int unsigned fail_count = 0;

    // byte length per packet type
    function automatic logic [P_LEN-1:0] length_for(input logic [PTYPE_LEN-1:0] ptype);
        case (ptype[3:2])
            2'd1:    return LEN_F1;
            2'd2:    return LEN_F2;
            2'd3:    return (ptype[1:0] == 2'd1) ? LEN_F3_TRAP : LEN_F3_START;
            default: return '0;
        endcase
    endfunction

    // back to back packets need two back to back accepts
    back_to_back: assert property (@(posedge clk_i) disable iff (!rst_ni)
        packet_valid_i && $past(packet_valid_i) |-> $past(inst_valid_i) && $past(inst_valid_i, 2)
    ) else begin
        fail_count++;
        $error("packets on consecutive cycles without two accepted instructions");
    end

    length_matches: assert property (@(posedge clk_i) disable iff (!rst_ni)
        packet_valid_i |-> packet_length_i == length_for(packet_type_i)
    ) else begin
        fail_count++;
        $error("packet length does not fit packet type %h", packet_type_i);
    end

    // count field sits in bits 67..63
    f1_count_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
        packet_valid_i && packet_type_i[3:2] == 2'd1 |-> packet_payload_i[67:63] != 5'd0
    ) else begin
        fail_count++;
        $error("format 1 packet with a zero branch count");
    end

endmodule

bind trace_encoder trace_encoder_checker i_checker (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .inst_valid_i     (inst_valid_i),
    .packet_valid_i   (packet_valid_o),
    .packet_type_i    (packet_type_o),
    .packet_length_i  (packet_length_o),
    .packet_payload_i (packet_payload_o)
);

// ==== trace_encoder_tb.sv ====
// self-checking testbench for the trace encoder
// a table of retired instructions with expected packets, compared at packet_valid_o
module trace_encoder_tb import trace_pkg::*; ();

    localparam int unsigned CLK_PERIOD   = 10;
    localparam int unsigned RESET_CYCLES = 4;
    localparam int unsigned MAX_GAP      = 3;

    // instruction encodings, only the opcode matters
    localparam logic [31:0] NOP  = 32'h00000013;
    localparam logic [31:0] BEQ  = 32'h00b50463;
    localparam logic [31:0] JALR = 32'h00008067;
    localparam logic [1:0]  PRIV_M = 2'b11;
    localparam logic [1:0]  PRIV_S = 2'b01;

    // format in the high bits, subformat in the low bits
    localparam logic [3:0] TYPE_START = {F3, SUB_START};
    localparam logic [3:0] TYPE_TRAP  = {F3, SUB_TRAP};
    localparam logic [3:0] TYPE_F2    = {F2, 2'b00};
    localparam logic [3:0] TYPE_F1    = {F1, 2'b00};

    typedef struct packed {
        logic                   en;
        logic                   valid;
        logic [31:0]            pc;
        logic [31:0]            inst;
        logic                   exc;
        logic [4:0]             cause;
        logic                   intr;
        logic [1:0]             priv;
        logic                   has_pkt;
        logic [PTYPE_LEN-1:0]   ptype;
        logic [P_LEN-1:0]       plen;
        logic [PAYLOAD_LEN-1:0] payload;
    } stim_row_t;

    typedef struct packed {
        logic [PTYPE_LEN-1:0]   ptype;
        logic [P_LEN-1:0]       plen;
        logic [PAYLOAD_LEN-1:0] payload;
    } packet_t;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   trace_enable_i;
    logic                   inst_valid_i;
    logic [31:0]            pc_i;
    logic [31:0]            inst_data_i;
    logic                   exception_i;
    logic                   interrupt_i;
    logic [4:0]             cause_i;
    logic [1:0]             priv_lvl_i;
    logic                   packet_valid_o;
    logic [PTYPE_LEN-1:0]   packet_type_o;
    logic [P_LEN-1:0]       packet_length_o;
    logic [PAYLOAD_LEN-1:0] packet_payload_o;

    stim_row_t   rows[$];
    packet_t     expected_q[$];
    int unsigned errors;
    int unsigned checked;
    int          seed = 81;
    bit          table_built = 1'b0;

    trace_encoder i_trace_encoder (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .trace_enable_i   (trace_enable_i),
        .inst_valid_i     (inst_valid_i),
        .pc_i             (pc_i),
        .inst_data_i      (inst_data_i),
        .exception_i      (exception_i),
        .interrupt_i      (interrupt_i),
        .cause_i          (cause_i),
        .priv_lvl_i       (priv_lvl_i),
        .packet_valid_o   (packet_valid_o),
        .packet_type_o    (packet_type_o),
        .packet_length_o  (packet_length_o),
        .packet_payload_o (packet_payload_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // payload layouts, address always in bits 31..0
    function automatic logic [71:0] start_payload(input logic [31:0] pc, input logic [1:0] priv);
        logic [71:0] p;
        p = '0;
        p[31:0]  = pc;
        p[33:32] = priv;
        return p;
    endfunction

    function automatic logic [71:0] trap_payload(input logic [31:0] pc, input logic [4:0] cause,
                                                 input logic intr);
        logic [71:0] p;
        p = '0;
        p[31:0]  = pc;
        p[36:32] = cause;
        p[37]    = intr;
        return p;
    endfunction

    function automatic logic [71:0] f1_payload(input logic [31:0] pc, input logic [30:0] map,
                                               input logic [4:0] count);
        logic [71:0] p;
        p = '0;
        p[31:0]  = pc;
        p[62:32] = map;
        p[67:63] = count;
        return p;
    endfunction

    function automatic logic [71:0] f2_payload(input logic [31:0] pc);
        logic [71:0] p;
        p = '0;
        p[31:0] = pc;
        return p;
    endfunction

    task automatic add_row(input logic en, input logic valid, input logic [31:0] pc,
                           input logic [31:0] inst, input logic exc, input logic [4:0] cause,
                           input logic intr, input logic [1:0] priv);
        stim_row_t r;
        r       = '0;
        r.en    = en;
        r.valid = valid;
        r.pc    = pc;
        r.inst  = inst;
        r.exc   = exc;
        r.cause = cause;
        r.intr  = intr;
        r.priv  = priv;
        rows.push_back(r);
    endtask

    task automatic add_inst(input logic [31:0] pc, input logic [31:0] inst, input logic [1:0] priv);
        add_row(1'b1, 1'b1, pc, inst, 1'b0, 5'd0, 1'b0, priv);
    endtask

    // packet for instruction k comes out when k+2 is accepted
    task automatic expect_on_last(input logic [3:0] ptype, input logic [3:0] plen,
                                  input logic [71:0] payload);
        stim_row_t r;
        r = rows[rows.size() - 1];
        rows.pop_back();
        r.has_pkt = 1'b1;
        r.ptype   = ptype;
        r.plen    = plen;
        r.payload = payload;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0] pc;
        logic [31:0] last_branch_pc;
        logic [30:0] fill_map;
        logic        taken;
        // start packet, then branches taken / not / taken ended by a jalr
        add_inst(32'h1000, NOP, PRIV_M);
        add_inst(32'h1004, BEQ, PRIV_M);
        add_inst(32'h1100, BEQ, PRIV_M);
        expect_on_last(TYPE_START, LEN_F3_START, start_payload(32'h1000, PRIV_M));
        add_inst(32'h1104, BEQ, PRIV_M);
        add_inst(32'h1200, JALR, PRIV_M);
        add_inst(32'h2000, NOP, PRIV_M);
        add_inst(32'h2004, JALR, PRIV_M);
        add_inst(32'h3000, NOP, PRIV_M);
        expect_on_last(TYPE_F1, LEN_F1, f1_payload(32'h2000, 31'h2, 5'd3));
        // exception, handler starts with a not taken branch
        add_row(1'b1, 1'b1, 32'h3004, NOP, 1'b1, 5'd2, 1'b0, PRIV_M);
        add_inst(32'h8000, BEQ, PRIV_M);
        expect_on_last(TYPE_F2, LEN_F2, f2_payload(32'h3000));
        add_inst(32'h8004, NOP, PRIV_M);
        add_inst(32'h8008, JALR, PRIV_M);
        expect_on_last(TYPE_TRAP, LEN_F3_TRAP, trap_payload(32'h8000, 5'd2, 1'b0));
        add_inst(32'h9000, NOP, PRIV_M);
        // 31 branches with no discontinuity fill the map
        pc             = 32'h9004;
        last_branch_pc = pc;
        fill_map       = '0;
        for (int j = 0; j < 31; j++) begin
            taken = (j % 3) == 1;
            add_inst(pc, BEQ, PRIV_M);
            if (j == 1) begin
                // handler branch alone in the map after the jalr
                expect_on_last(TYPE_F1, LEN_F1, f1_payload(32'h9000, 31'h1, 5'd1));
            end
            if (!taken) begin
                fill_map = fill_map | (31'd1 << j);
            end
            last_branch_pc = pc;
            pc = taken ? pc + 32'h40 : pc + 32'h4;
        end
        // a jalr and its target are still pending when trace goes off
        add_inst(pc, JALR, PRIV_M);
        add_inst(pc + 32'h4, NOP, PRIV_M);
        expect_on_last(TYPE_F1, LEN_F1, f1_payload(last_branch_pc, fill_map, 5'd31));
        // trace off, the pending pair and these rows give nothing
        add_row(1'b0, 1'b1, 32'hf000, NOP, 1'b0, 5'd0, 1'b0, PRIV_M);
        add_row(1'b0, 1'b1, 32'hf004, NOP, 1'b0, 5'd0, 1'b0, PRIV_M);
        // back on in S mode, fresh start then an interrupt trap
        add_inst(32'ha000, NOP, PRIV_S);
        add_inst(32'ha004, NOP, PRIV_S);
        add_inst(32'ha008, NOP, PRIV_S);
        expect_on_last(TYPE_START, LEN_F3_START, start_payload(32'ha000, PRIV_S));
        add_row(1'b1, 1'b1, 32'ha00c, NOP, 1'b1, 5'd7, 1'b1, PRIV_S);
        add_inst(32'hc000, NOP, PRIV_M);
        add_inst(32'hc004, NOP, PRIV_M);
        add_inst(32'hc008, NOP, PRIV_M);
        expect_on_last(TYPE_TRAP, LEN_F3_TRAP, trap_payload(32'hc000, 5'd7, 1'b1));
    endtask

    task automatic drive_row(input stim_row_t r);
        trace_enable_i = r.en;
        inst_valid_i   = r.valid;
        pc_i           = r.pc;
        inst_data_i    = r.inst;
        exception_i    = r.exc;
        cause_i        = r.cause;
        interrupt_i    = r.intr;
        priv_lvl_i     = r.priv;
    endtask

    task automatic drive_idle(input logic en);
        trace_enable_i = en;
        inst_valid_i   = 1'b0;
    endtask

    task automatic check_packet();
        packet_t exp;
        if (expected_q.size() == 0) begin
            $display("error: unexpected packet of type %h at pc %h",
                     packet_type_o, packet_payload_o[31:0]);
            errors++;
        end else begin
            exp = expected_q.pop_front();
            checked++;
            if (packet_type_o !== exp.ptype) begin
                $display("mismatch packet_type_o: got %h expected %h", packet_type_o, exp.ptype);
                errors++;
            end
            if (packet_length_o !== exp.plen) begin
                $display("mismatch packet_length_o: got %h expected %h",
                         packet_length_o, exp.plen);
                errors++;
            end
            if (packet_payload_o !== exp.payload) begin
                $display("mismatch packet_payload_o: got %h expected %h",
                         packet_payload_o, exp.payload);
                errors++;
            end
        end
    endtask

    // outputs settle after the rising edge, sample on the falling one
    always @(negedge clk_i) begin
        if (packet_valid_o) begin
            check_packet();
        end
    end

    // limit scales with the table, worst case gap on every row
    initial begin
        int unsigned timeout;
        wait (table_built);
        timeout = (rows.size() * (MAX_GAP + 1) + RESET_CYCLES + 20) * CLK_PERIOD * 2;
        #(timeout);
        $display("error: simulation timed out after %0d time units", timeout);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int unsigned gap;
        int unsigned drain;
        int unsigned assert_fails;
        clk_i          = 1'b0;
        rst_ni         = 1'b0;
        trace_enable_i = 1'b0;
        inst_valid_i   = 1'b0;
        pc_i           = '0;
        inst_data_i    = '0;
        exception_i    = 1'b0;
        interrupt_i    = 1'b0;
        cause_i        = '0;
        priv_lvl_i     = '0;
        errors         = 0;
        checked        = 0;
        build_table();
        table_built = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            // random idle cycles ahead of each row
            gap = $unsigned($random(seed)) % (MAX_GAP + 1);
            repeat (gap) begin
                @(posedge clk_i);
                #1;
                drive_idle(rows[i].en);
            end
            @(posedge clk_i);
            #1;
            drive_row(rows[i]);
            if (rows[i].has_pkt) begin
                expected_q.push_back({rows[i].ptype, rows[i].plen, rows[i].payload});
            end
        end
        @(posedge clk_i);
        #1;
        drive_idle(1'b1);
        // wait for the last packets, bounded
        drain = 0;
        while (expected_q.size() != 0 && drain < 10) begin
            @(posedge clk_i);
            drain++;
        end
        @(posedge clk_i);
        @(negedge clk_i);
        // let the monitor finish with this edge first
        #1;
        if (expected_q.size() != 0) begin
            $display("error: %0d expected packets never came out", expected_q.size());
            errors++;
        end
        assert_fails = i_trace_encoder.i_checker.fail_count;
        $display("%0d errors, %0d assertion failures, %0d packets checked",
                 errors, assert_fails, checked);
        if (errors == 0 && assert_fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== trace_encoder.f ====
trace_pkg.sv
trace_if.sv
retire_window.sv
branch_map.sv
packet_decider.sv
packet_emitter.sv
trace_encoder.sv
trace_encoder_checker.sv
trace_encoder_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the trace encoder testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Checks failed"

if ! verilator --binary --timing --assert --top-module trace_encoder_tb \
        -f trace_encoder.f -o sim_trace_encoder; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_trace_encoder +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
    exit 1
fi

exit 0
